// File: hw/memmap_pkg.sv
/* Main CPU memory map */

`default_nettype none

package memmap_pkg;

    // Bus targets behind the region decoder
    typedef enum logic [2:0] {
        REG_ROM,
        REG_RAM,
        REG_IO,
        REG_NONE
    } region_t;

    // 3-bit region field inside the word address
    localparam int RGN_LSB = 17;
    localparam int RGN_MSB = RGN_LSB + 2;

    localparam logic [2:0] RGN_RAM = 3'd6;  // Work RAM page
    localparam logic [2:0] RGN_IO  = 3'd7;  // Cabinet I/O page
    // Field values 0 to 5 fall into program ROM

    // Upper address bits, nonzero means nothing answers
    localparam int HI_MSB = 23;
    localparam int HI_LSB = 20;

    localparam logic [15:0] OPEN_BUS = 16'hffff;

    // FC[1:0] pattern of a program-space (opcode) fetch
    localparam logic [1:0] FC_PROG = 2'b10;

endpackage

`default_nettype wire

// File: hw/cab_pkg.sv
/* Cabinet I/O definitions */

`default_nettype none

package cab_pkg;

    // Sub-block select on A[6:4], unlisted codes read as 0xFF
    typedef enum logic [2:0] {
        IO_PPI    = 3'd0,
        IO_INPUTS = 3'd1,
        IO_ADC    = 3'd3
    } io_sub_t;

    // PPI port A control byte
    typedef union packed {
        logic [7:0] raw;            // CPU view
        struct packed {
            logic [1:0] obj_cfg;    // Object engine / colour mixer config
            logic       video_en;
            logic [2:0] adc_ch;     // Analog channel for ADC reads
            logic       spare;
            logic       snd_rstb;   // Sound CPU reset, active low
        } fld;
    } ppi_ctrl_u;

    localparam logic [2:0] ADC_STEER = 3'd0;
    localparam logic [2:0] ADC_GAS   = 3'd1;
    localparam logic [2:0] ADC_BRAKE = 3'd2;

    // Pedals sit around mid-scale
    localparam logic [7:0] ADC_OFFSET = 8'h80;

endpackage

`default_nettype wire

// File: hw/rom_decrypt.sv
/* Program ROM decryption */

`default_nettype none

module rom_decrypt #(
    parameter int KEY_AW = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rom_cs,
    input  logic              rom_ok,
    input  logic [15:0]       rom_data,
    input  logic [KEY_AW-1:0] addr_key,
    input  logic [2:0]        fc,
    input  logic              dec_en,
    input  logic              prog_we,
    input  logic [KEY_AW-1:0] prog_addr,
    input  logic [7:0]        prog_data,
    output logic [15:0]       dec_data,
    output logic              dec_ok
);

    localparam int KEY_N = 2 ** KEY_AW;

    logic [7:0]  key_mem [KEY_N];
    logic [7:0]  k;
    logic        opcode;
    logic [15:0] dec_word;

    // Key table loader
    always_ff @(posedge clk) begin
        if (prog_we) begin
            key_mem[prog_addr] <= prog_data;
        end
    end

    assign k      = key_mem[addr_key];
    assign opcode = fc[1:0] == memmap_pkg::FC_PROG;

    always_comb begin
        if (!dec_en) begin
            dec_word = rom_data;    // Plain ROM
        end else if (opcode) begin
            dec_word = rom_data ^ {k, k};
        end else begin
            // Data reads, low byte keyed then bytes swapped
            dec_word = {rom_data[7:0] ^ k, rom_data[15:8]};
        end
    end

    // Output register, ok drops as soon as the ROM select goes away
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_ok <= 1'b0;
        end else if (!rom_cs) begin
            dec_ok <= 1'b0;
        end else if (rom_ok) begin
            dec_ok <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rom_cs && rom_ok) begin
            dec_data <= dec_word;
        end
    end

endmodule

`default_nettype wire

// File: hw/cab_io.sv
/* Cabinet inputs and PPI control */

`default_nettype none

module cab_io (
    input  logic        clk,
    input  logic        rst,
    input  logic        io_cs,
    input  logic [6:1]  addr_sub,
    input  logic        rnw,
    input  logic        ldsn,           // Lower data strobe
    input  logic [7:0]  wr_byte,
    input  logic [7:0]  joystick1,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [15:0] joyana1,
    input  logic [15:0] joyana2,
    output logic [7:0]  io_byte,
    output logic [1:0]  obj_cfg,
    output logic        video_en,
    output logic        snd_rstb
);

    cab_pkg::ppi_ctrl_u ctrl;
    cab_pkg::io_sub_t   sub;

    assign sub = cab_pkg::io_sub_t'(addr_sub[6:4]);

    // Byte writes to the PPI land on port A
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl.raw <= 8'h00;  // Video off, sound held in reset
        end else if (io_cs && !rnw && !ldsn && sub == cab_pkg::IO_PPI) begin
            ctrl.raw <= wr_byte;
        end
    end

    assign obj_cfg  = ctrl.fld.obj_cfg;
    assign video_en = ctrl.fld.video_en;
    assign snd_rstb = ctrl.fld.snd_rstb;

    always_comb begin
        io_byte = 8'hff;
        case (sub)
            cab_pkg::IO_PPI: io_byte = ctrl.raw;
            cab_pkg::IO_INPUTS: begin
                case (addr_sub[2:1])
                    2'd0: io_byte = {coin_input, 1'b0, joystick1[4], start_button[0],
                                     service, dip_test, 1'b1};
                    2'd1: io_byte = 8'hff;
                    2'd2: io_byte = dipsw_a;
                    default: io_byte = dipsw_b;
                endcase
            end
            cab_pkg::IO_ADC: begin
                case (ctrl.fld.adc_ch)
                    cab_pkg::ADC_STEER: io_byte = joyana1[7:0];
                    cab_pkg::ADC_GAS:   io_byte = joyana1[15:8] + cab_pkg::ADC_OFFSET;
                    cab_pkg::ADC_BRAKE: io_byte = joyana2[15:8] + cab_pkg::ADC_OFFSET;
                    default: io_byte = 8'hff;   // No converter behind it
                endcase
            end
            default: io_byte = 8'hff;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/main_bus.sv
/* Main bus decoder and data return */

`default_nettype none

module main_bus (
    input  logic        clk,
    input  logic        rst,
    input  logic [23:1] addr,
    input  logic        asn,
    input  logic [1:0]  dsn,
    input  logic        rnw,
    input  logic [2:0]  fc,
    input  logic [15:0] dec_data,
    input  logic        dec_ok,
    input  logic [15:0] ram_data,
    input  logic        ram_ok,
    input  logic [7:0]  io_byte,
    output logic        rom_cs,
    output logic        ram_cs,
    output logic        io_cs,
    output logic [15:0] bus_din,
    output logic        bus_ack
);

    memmap_pkg::region_t rgn;
    logic [2:0]  rgn_fld;
    logic        none_cs;   // Open-bus cycle in progress
    logic        done;      // Current cycle already acknowledged
    logic        ready;
    logic [15:0] rd_data;

    assign rgn_fld = addr[memmap_pkg::RGN_MSB:memmap_pkg::RGN_LSB];

    always_comb begin
        if (addr[memmap_pkg::HI_MSB:memmap_pkg::HI_LSB] != '0) begin
            rgn = memmap_pkg::REG_NONE;
        end else if (rgn_fld == memmap_pkg::RGN_IO) begin
            rgn = memmap_pkg::REG_IO;
        end else if (rgn_fld == memmap_pkg::RGN_RAM) begin
            // A strobeless write has nothing to store
            rgn = (rnw || dsn != 2'b11) ? memmap_pkg::REG_RAM : memmap_pkg::REG_NONE;
        end else begin
            rgn = rnw ? memmap_pkg::REG_ROM : memmap_pkg::REG_NONE; // ROM is read only
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs  <= 1'b0;
            ram_cs  <= 1'b0;
            io_cs   <= 1'b0;
            none_cs <= 1'b0;
        end else begin
            rom_cs  <= !asn && rgn == memmap_pkg::REG_ROM;
            ram_cs  <= !asn && rgn == memmap_pkg::REG_RAM;
            io_cs   <= !asn && rgn == memmap_pkg::REG_IO;
            none_cs <= !asn && rgn == memmap_pkg::REG_NONE;
        end
    end

    // Only one select is ever high
    always_comb begin
        ready   = 1'b0;
        rd_data = memmap_pkg::OPEN_BUS;
        if (rom_cs) begin
            ready   = dec_ok;
            rd_data = dec_data;
        end else if (ram_cs) begin
            ready   = ram_ok;
            rd_data = ram_data;
        end else if (io_cs) begin
            ready   = 1'b1;
            rd_data = {8'hff, io_byte};
        end else if (none_cs) begin
            ready = 1'b1;
        end
    end

    // Single acknowledge per strobe until AS goes high again
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_ack <= 1'b0;
            done    <= 1'b0;
            bus_din <= 16'h0000;
        end else begin
            bus_ack <= 1'b0;
            if (asn) begin
                done <= 1'b0;
            end else if (ready && !done) begin
                bus_ack <= 1'b1;
                done    <= 1'b1;
                bus_din <= rd_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/main_board.sv
/* Main CPU board bus side */

`default_nettype none

module main_board #(
    parameter int KEY_AW = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [23:1]       addr,
    input  logic              asn,
    input  logic [1:0]        dsn,
    input  logic              rnw,
    input  logic [2:0]        fc,
    input  logic [15:0]       bus_dout,
    input  logic [15:0]       rom_data,
    input  logic              rom_ok,
    input  logic [15:0]       ram_data,
    input  logic              ram_ok,
    input  logic              dec_en,
    input  logic              prog_we,
    input  logic [KEY_AW-1:0] prog_addr,
    input  logic [7:0]        prog_data,
    input  logic [7:0]        joystick1,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic              service,
    input  logic              dip_test,
    input  logic [7:0]        dipsw_a,
    input  logic [7:0]        dipsw_b,
    input  logic [15:0]       joyana1,
    input  logic [15:0]       joyana2,
    output logic [15:0]       bus_din,
    output logic              bus_ack,
    output logic              rom_cs,
    output logic              ram_cs,
    output logic [19:1]       mem_addr,
    output logic [1:0]        obj_cfg,
    output logic              video_en,
    output logic              snd_rstb
);

    logic [15:0] dec_data;
    logic        dec_ok;
    logic        io_cs;
    logic [7:0]  io_byte;

    assign mem_addr = addr[19:1];   // ROM and RAM share the low address lines

    main_bus u_bus (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .addr     ( addr     ),
        .asn      ( asn      ),
        .dsn      ( dsn      ),
        .rnw      ( rnw      ),
        .fc       ( fc       ),
        .dec_data ( dec_data ),
        .dec_ok   ( dec_ok   ),
        .ram_data ( ram_data ),
        .ram_ok   ( ram_ok   ),
        .io_byte  ( io_byte  ),
        .rom_cs   ( rom_cs   ),
        .ram_cs   ( ram_cs   ),
        .io_cs    ( io_cs    ),
        .bus_din  ( bus_din  ),
        .bus_ack  ( bus_ack  )
    );

    rom_decrypt #(
        .KEY_AW ( KEY_AW )
    ) u_dec (
        .clk       ( clk              ),
        .rst       ( rst              ),
        .rom_cs    ( rom_cs           ),
        .rom_ok    ( rom_ok           ),
        .rom_data  ( rom_data         ),
        .addr_key  ( addr[KEY_AW:1]   ),  // Key follows low word address
        .fc        ( fc               ),
        .dec_en    ( dec_en           ),
        .prog_we   ( prog_we          ),
        .prog_addr ( prog_addr        ),
        .prog_data ( prog_data        ),
        .dec_data  ( dec_data         ),
        .dec_ok    ( dec_ok           )
    );

    cab_io u_cab (
        .clk          ( clk            ),
        .rst          ( rst            ),
        .io_cs        ( io_cs          ),
        .addr_sub     ( addr[6:1]      ),
        .rnw          ( rnw            ),
        .ldsn         ( dsn[0]         ),
        .wr_byte      ( bus_dout[7:0]  ),
        .joystick1    ( joystick1      ),
        .start_button ( start_button   ),
        .coin_input   ( coin_input     ),
        .service      ( service        ),
        .dip_test     ( dip_test       ),
        .dipsw_a      ( dipsw_a        ),
        .dipsw_b      ( dipsw_b        ),
        .joyana1      ( joyana1        ),
        .joyana2      ( joyana2        ),
        .io_byte      ( io_byte        ),
        .obj_cfg      ( obj_cfg        ),
        .video_en     ( video_en       ),
        .snd_rstb     ( snd_rstb       )
    );

endmodule

`default_nettype wire

// File: tb/main_board_tb.sv
/* Main board bus testbench */

`default_nettype none

module main_board_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int KEY_AW = 4;
    localparam int N_ROM = 64;
    localparam int N_RAM = 32;
    localparam int N_CTRL = 16;
    localparam int N_MISC = 24;
    localparam int N_BUS = 1 + N_ROM + 2 * N_RAM + 4 * N_CTRL + 4 * N_MISC;
    localparam int ACK_LIMIT = 30;

    logic clk;
    logic rst;
    logic [23:1] addr;
    logic asn;
    logic [1:0] dsn;
    logic rnw;
    logic [2:0] fc;
    logic [15:0] bus_dout;
    logic [15:0] rom_data;
    logic rom_ok;
    logic [15:0] ram_data;
    logic ram_ok;
    logic dec_en;
    logic prog_we;
    logic [KEY_AW-1:0] prog_addr;
    logic [7:0] prog_data;
    logic [7:0] joystick1;
    logic [1:0] start_button;
    logic [1:0] coin_input;
    logic service;
    logic dip_test;
    logic [7:0] dipsw_a;
    logic [7:0] dipsw_b;
    logic [15:0] joyana1;
    logic [15:0] joyana2;
    logic [15:0] bus_din;
    logic bus_ack;
    logic rom_cs;
    logic ram_cs;
    logic [19:1] mem_addr;
    logic [1:0] obj_cfg;
    logic video_en;
    logic snd_rstb;

    logic [15:0] ram_mem [256];         // RAM device contents
    logic [15:0] ref_ram [256];         // Expected RAM contents
    logic [7:0]  ref_key [2**KEY_AW];
    logic [7:0]  ref_ctrl;
    int errors;
    int checks;
    int acks;
    int cycles;
    int rom_wait;
    int ram_wait;

    main_board #(.KEY_AW(KEY_AW)) dut_i (.*);

    function automatic logic [15:0] rom_word(input logic [19:1] a);
        return a[16:1] ^ {a[19:17], 13'h0} ^ 16'h9e37;
    endfunction

    function automatic logic [15:0] ram_fill(input logic [7:0] i);
        return {~i, i};
    endfunction

    // Opcode fetches key both bytes while data reads key the low byte and swap
    function automatic logic [15:0] expect_rom(input logic [23:1] a, input logic [2:0] f,
                                               input logic en);
        logic [15:0] w;
        logic [7:0]  k;
        w = rom_word(a[19:1]);
        k = ref_key[a[KEY_AW:1]];
        if (!en) return w;
        if (f[1:0] == 2'b10) return w ^ {k, k};
        return {w[7:0] ^ k, w[15:8]};
    endfunction

    function automatic logic [23:1] io_addr(input logic [2:0] sub, input logic [1:0] w);
        return {4'h0, 3'd7, 10'($urandom), sub, 1'($urandom), w};
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assign rom_data = rom_word(mem_addr);
    assign ram_data = ram_mem[mem_addr[8:1]];

    // ROM answers after 0 to 5 wait cycles
    initial begin : rom_model
        rom_ok = 1'b0;
        rom_wait = 0;
        forever begin
            @(posedge clk);
            #2;
            if (!rom_cs) begin
                rom_ok = 1'b0;
                rom_wait = $urandom_range(5);
            end else if (rom_wait == 0) begin
                rom_ok = 1'b1;
            end else begin
                rom_wait--;
            end
        end
    end

    initial begin : ram_model
        ram_ok = 1'b0;
        ram_wait = 0;
        for (int i = 0; i < 256; i++) ram_mem[i[7:0]] = ram_fill(i[7:0]);
        forever begin
            @(posedge clk);
            #2;
            if (!ram_cs) begin
                ram_ok = 1'b0;
                ram_wait = $urandom_range(5);
            end else if (ram_wait != 0) begin
                ram_wait--;
            end else if (!ram_ok) begin
                ram_ok = 1'b1;
                if (!rnw && !dsn[1]) ram_mem[mem_addr[8:1]][15:8] = bus_dout[15:8];
                if (!rnw && !dsn[0]) ram_mem[mem_addr[8:1]][7:0] = bus_dout[7:0];
            end
        end
    end

    initial begin : ack_monitor
        acks = 0;
        forever begin
            @(posedge clk);
            #1;
            if (bus_ack) acks++;
        end
    end

    // ROM and RAM selects follow AS and the address decode
    initial begin : select_monitor
        logic exp_rom;
        logic exp_ram;
        forever begin
            @(posedge clk);
            #1;
            exp_rom = !asn && addr[23:20] == 4'h0 && addr[19:17] <= 3'd5 && rnw;
            exp_ram = !asn && addr[23:20] == 4'h0 && addr[19:17] == 3'd6;
            if (rom_cs !== exp_rom || ram_cs !== exp_ram) begin
                report_value("chip_selects", {14'h0, exp_rom, exp_ram},
                             {14'h0, rom_cs, ram_cs});
            end
        end
    end

    initial begin : watchdog
        repeat (N_BUS * 40 + 400) @(posedge clk);
        $display("Timeout, bus cycles still running after %0d clocks", N_BUS * 40 + 400);
        $display("Something failed");
        $finish;
    end

    task automatic report_value(input string name, input logic [15:0] exp,
                                input logic [15:0] act);
        errors++;
        $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
    endtask

    // One 68000-style cycle with AS held until acknowledge and one idle clock after
    task automatic bus_cycle(input logic [23:1] a, input logic wr, input logic [1:0] ds,
                             input logic [2:0] f, input logic [15:0] wd,
                             output logic [15:0] rd, output int lat);
        lat = 0;
        addr = a;
        rnw = !wr;
        dsn = ds;
        fc = f;
        bus_dout = wd;
        asn = 1'b0;
        do begin
            @(posedge clk);
            #2;
            lat++;
        end while (!bus_ack && lat < ACK_LIMIT);
        rd = bus_din;
        if (!bus_ack) begin
            errors++;
            $display("No bus_ack within %0d cycles for address %h", ACK_LIMIT, a);
        end
        cycles++;
        asn = 1'b1;
        @(posedge clk);
        #2;
    endtask

    task automatic read_check(input string name, input logic [23:1] a, input logic [2:0] f,
                              input logic [15:0] exp, input int exp_lat);
        logic [15:0] rd;
        int lat;
        bus_cycle(a, 1'b0, 2'b00, f, 16'h0000, rd, lat);
        checks++;
        if (rd !== exp) report_value(name, exp, rd);
        if (exp_lat > 0 && lat != exp_lat) begin
            errors++;
            $display("%s acknowledged after %0d cycles instead of %0d", name, lat, exp_lat);
        end
    endtask

    task automatic write_cycle(input string name, input logic [23:1] a, input logic [1:0] ds,
                               input logic [15:0] wd, input int exp_lat);
        logic [15:0] rd;
        int lat;
        bus_cycle(a, 1'b1, ds, 3'b101, wd, rd, lat);
        if (exp_lat > 0 && lat != exp_lat) begin
            errors++;
            $display("%s acknowledged after %0d cycles instead of %0d", name, lat, exp_lat);
        end
    endtask

    task automatic load_key(input logic [KEY_AW-1:0] i, input logic [7:0] v);
        prog_we = 1'b1;
        prog_addr = i;
        prog_data = v;
        ref_key[i] = v;
        @(posedge clk);
        #2;
        prog_we = 1'b0;
    endtask

    task automatic shuffle_cabinet();
        joystick1 = 8'($urandom);
        start_button = 2'($urandom);
        coin_input = 2'($urandom);
        service = 1'($urandom);
        dip_test = 1'($urandom);
        dipsw_a = 8'($urandom);
        dipsw_b = 8'($urandom);
        joyana1 = 16'($urandom);
        joyana2 = 16'($urandom);
    endtask

    initial begin : stimulus
        logic [23:1] a;
        logic [2:0]  f;
        logic [2:0]  sub;
        logic [1:0]  w;
        logic [1:0]  ds;
        logic [15:0] wd;
        logic [7:0]  idx;
        logic [7:0]  cb;
        logic [7:0]  exp_b;
        void'($urandom(48747));
        errors = 0;
        checks = 0;
        cycles = 0;
        rst = 1'b1;
        addr = '0;
        asn = 1'b1;
        dsn = 2'b11;
        rnw = 1'b1;
        fc = 3'b101;
        bus_dout = '0;
        dec_en = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        shuffle_cabinet();
        for (int i = 0; i < 256; i++) ref_ram[i[7:0]] = ram_fill(i[7:0]);
        ref_ctrl = 8'h00;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;

        // Reset state of the control byte
        checks++;
        if ({obj_cfg, video_en, snd_rstb} !== 4'b0000) begin
            report_value("reset_fields", 16'h0000, {12'h000, obj_cfg, video_en, snd_rstb});
        end
        read_check("reset_ppi", io_addr(3'd0, 2'($urandom)), 3'b101, 16'hff00, 2);

        for (int i = 0; i < 2**KEY_AW; i++) load_key(i[KEY_AW-1:0], 8'($urandom));
        for (int n = 0; n < N_ROM; n++) begin
            if (n == N_ROM / 2) begin
                for (int j = 0; j < 4; j++) load_key(KEY_AW'($urandom), 8'($urandom));
            end
            a = {4'h0, 3'($urandom_range(5)), 16'($urandom)};
            f = {1'($urandom), 1'($urandom) ? 2'b10 : 2'b01};
            dec_en = 1'($urandom);
            read_check("rom_read", a, f, expect_rom(a, f, dec_en), 0);
        end
        dec_en = 1'b0;

        for (int n = 0; n < N_RAM; n++) begin
            idx = 8'($urandom);
            wd = 16'($urandom);
            ds = 2'($urandom_range(2));     // Word, upper or lower byte
            write_cycle("ram_write", {4'h0, 3'd6, 8'($urandom), idx}, ds, wd, 0);
            if (!ds[1]) ref_ram[idx][15:8] = wd[15:8];
            if (!ds[0]) ref_ram[idx][7:0] = wd[7:0];
            if (1'($urandom)) idx = 8'($urandom);
            read_check("ram_read", {4'h0, 3'd6, 8'($urandom), idx}, 3'b101, ref_ram[idx], 0);
        end

        for (int n = 0; n < N_CTRL; n++) begin
            shuffle_cabinet();
            cb = 8'($urandom);
            cb[4:2] = 3'(n % 5);
            write_cycle("ppi_write", io_addr(3'd0, 2'($urandom)),
                        1'($urandom) ? 2'b00 : 2'b10, {8'($urandom), cb}, 2);
            ref_ctrl = cb;
            // Upper strobe alone leaves port A untouched
            write_cycle("ppi_upper", io_addr(3'd0, 2'($urandom)), 2'b01, 16'($urandom), 2);
            checks++;
            if ({obj_cfg, video_en, snd_rstb} !== {ref_ctrl[7:5], ref_ctrl[0]}) begin
                report_value("ppi_fields", {12'h000, ref_ctrl[7:5], ref_ctrl[0]},
                             {12'h000, obj_cfg, video_en, snd_rstb});
            end
            read_check("ppi_read", io_addr(3'd0, 2'($urandom)), 3'b101, {8'hff, ref_ctrl}, 2);
            case (ref_ctrl[4:2])
                3'd0: exp_b = joyana1[7:0];
                3'd1: exp_b = joyana1[15:8] + 8'h80;
                3'd2: exp_b = joyana2[15:8] + 8'h80;
                default: exp_b = 8'hff;
            endcase
            read_check("adc_read", io_addr(3'd3, 2'($urandom)), 3'b101, {8'hff, exp_b}, 2);
        end

        for (int n = 0; n < N_MISC; n++) begin
            shuffle_cabinet();
            w = 2'($urandom);
            case (w)
                2'd0: exp_b = {coin_input, 1'b0, joystick1[4], start_button[0],
                               service, dip_test, 1'b1};
                2'd1: exp_b = 8'hff;
                2'd2: exp_b = dipsw_a;
                default: exp_b = dipsw_b;
            endcase
            read_check("input_read", io_addr(3'd1, w), 3'b101, {8'hff, exp_b}, 2);
            sub = 3'($urandom_range(7, 2));
            if (sub == 3'd3) sub = 3'd2;    // Skip the ADC
            read_check("io_unused", io_addr(sub, 2'($urandom)), 3'b101, 16'hffff, 2);
            a = {4'($urandom_range(15, 1)), 19'($urandom)};
            read_check("open_bus", a, 3'b101, 16'hffff, 2);
            a = {4'h0, 3'($urandom_range(5)), 16'($urandom)};
            write_cycle("rom_write", a, 2'b00, 16'($urandom), 2);
        end

        repeat (4) @(posedge clk);
        checks++;
        if (acks != cycles) begin
            errors++;
            $display("Saw %0d bus_ack pulses for %0d bus cycles", acks, cycles);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hw/memmap_pkg.sv
hw/cab_pkg.sv
hw/rom_decrypt.sv
hw/cab_io.sv
hw/main_bus.sv
hw/main_board.sv
tb/main_board_tb.sv

// File: Makefile
TOP = main_board_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f hw/*.sv tb/*.sv
	verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
